/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := lbp_tb
FILELIST := project.f
PASS     := *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '$(PASS)' > /dev/null

clean:
	rm -rf obj_dir

/* bench/lbp_model.svh */
`ifndef LBP_MODEL_SVH
`define LBP_MODEL_SVH

`include "lbp_consts.svh"

pixel_t    frame_mem [`LBP_IMG_H][`LBP_IMG_W];
lbp_code_t exp_code_q [$];
logic      exp_last_q [$];

// Unit steps for angle 45*k
// Rows grow downwards
int dx_tab [8] = '{1, 1, 0, -1, -1, -1, 0, 1};
int dy_tab [8] = '{0, -1, -1, -1, 0, 1, 1, 1};

// Circle sample in 8.16 for angle k around (cy, cx)
function automatic int circle_sample(int cy, int cx, int k);
    int dx, dy, n, o, wc, we, wi;
    dx = dx_tab[k];
    dy = dy_tab[k];
    if (k % 2 == 0) begin
        return int'(frame_mem[cy + `LBP_RADIUS * dy][cx + `LBP_RADIUS * dx]) << `LBP_FRAC_BITS;
    end
    n  = `LBP_DIAG_INT;
    o  = `LBP_DIAG_INT + 1;
    wc = (`LBP_DIAG_FRAC * `LBP_DIAG_FRAC) >> `LBP_FRAC_BITS;
    we = `LBP_DIAG_FRAC - wc;
    wi = (1 << `LBP_FRAC_BITS) - 2 * `LBP_DIAG_FRAC + wc;
    return int'(frame_mem[cy + n * dy][cx + n * dx]) * wi
         + int'(frame_mem[cy + n * dy][cx + o * dx]) * we
         + int'(frame_mem[cy + o * dy][cx + n * dx]) * we
         + int'(frame_mem[cy + o * dy][cx + o * dx]) * wc;
endfunction

function automatic lbp_code_t expected_code(int cy, int cx);
    lbp_code_t code;
    for (int k = 0; k < 8; k++) begin
        code[k] = circle_sample(cy, cx, k) >= (int'(frame_mem[cy][cx]) << `LBP_FRAC_BITS);
    end
    return code;
endfunction

// Codes of all interior centres in raster order
function automatic void build_expected();
    for (int cy = `LBP_RADIUS; cy < `LBP_IMG_H - `LBP_RADIUS; cy++) begin
        for (int cx = `LBP_RADIUS; cx < `LBP_IMG_W - `LBP_RADIUS; cx++) begin
            exp_code_q.push_back(expected_code(cy, cx));
            exp_last_q.push_back(cx == `LBP_IMG_W - `LBP_RADIUS - 1);
        end
    end
endfunction

`endif

/* bench/lbp_tb.sv */
`timescale 1ns/10ps

`include "lbp_consts.svh"

module lbp_tb;
    import lbp_pixel_pkg::*;

    localparam int W          = `LBP_IMG_W;
    localparam int H          = `LBP_IMG_H;
    localparam int NPIX       = W * H;
    localparam int EDGE       = 2 * `LBP_RADIUS;
    localparam int N_CODES    = (W - EDGE) * (H - EDGE);
    // Window and encoder add one cycle each
    localparam int CODE_LAT   = `LBP_INTERP_LAT + 2;
    localparam int DONE_LIMIT = 100;

    logic      clk;
    logic      rst_n;
    logic      start_i;
    logic      pix_valid_i;
    pixel_t    pix_i;
    logic      code_valid_o;
    lbp_code_t code_o;
    logic      code_row_last_o;
    logic      frame_done_o;
    logic      busy_o;

    int   errors = 0;
    int   checks = 0;
    int   tests = 0;
    int   failed_tests = 0;
    int   mark;
    bit   aborted = 1'b0;
    bit   streaming = 1'b0;
    int   cyc = 0;
    int   pix_cnt = 0;
    int   frame_codes = 0;
    logic done_due = 1'b0;
    int   stamp_q [$];

    `include "lbp_model.svh"

    lbp_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (start_i),
        .pix_valid_i     (pix_valid_i),
        .pix_i           (pix_i),
        .code_valid_o    (code_valid_o),
        .code_o          (code_o),
        .code_row_last_o (code_row_last_o),
        .frame_done_o    (frame_done_o),
        .busy_o          (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_code(string name, lbp_code_t got, lbp_code_t exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %02h expected %02h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // Output monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (streaming) begin
                check_flag("busy_o", busy_o, 1'b1);
            end
            if (pix_valid_i && streaming) begin
                if (pix_cnt % W >= EDGE && pix_cnt / W >= EDGE) begin
                    stamp_q.push_back(cyc);
                end
                pix_cnt = (pix_cnt + 1) % NPIX;
            end
            check_flag("frame_done_o", frame_done_o, done_due);
            done_due = 1'b0;
            if (code_valid_o) begin
                if (exp_code_q.size() == 0 || stamp_q.size() == 0) begin
                    $display("Unexpected code %02h at %0t with none outstanding", code_o, $time);
                    errors++;
                end else begin
                    check_code("code_o", code_o, exp_code_q.pop_front());
                    check_flag("code_row_last_o", code_row_last_o, exp_last_q.pop_front());
                    check_count("code latency", cyc - stamp_q.pop_front(), CODE_LAT);
                end
                frame_codes++;
                if (frame_codes == N_CODES) begin
                    done_due    = 1'b1;
                    frame_codes = 0;
                end
            end else begin
                check_flag("code_row_last_o", code_row_last_o, 1'b0);
            end
        end
        cyc++;
    end

    // Kinds 1 to 4 are flat tiles, two diagonal steps and flat ground with spikes
    function automatic void fill_frame(int kind);
        for (int r = 0; r < H; r++) begin
            for (int c = 0; c < W; c++) begin
                case (kind)
                    1: frame_mem[r][c] = pixel_t'(40 * (r / 4) + 25 * (c / 4));
                    2: frame_mem[r][c] = (r + c >= 13) ? 8'd200 : 8'd40;
                    3: frame_mem[r][c] = (c - r >= 3) ? 8'd180 : 8'd60;
                    4: frame_mem[r][c] = ((r * 7 + c * 3) % 11 == 0) ? 8'd140 : 8'd100;
                    default: frame_mem[r][c] = pixel_t'($urandom);
                endcase
            end
        end
    endfunction

    task automatic drive_frame(int gap_pct, bit poke_start);
        int n;
        n = 0;
        streaming = 1'b1;
        while (n < NPIX) begin
            @(posedge clk);
            start_i <= poke_start && (n == NPIX / 3);
            if (($urandom % 100) < gap_pct) begin
                pix_valid_i <= 1'b0;
            end else begin
                pix_valid_i <= 1'b1;
                pix_i       <= frame_mem[n / W][n % W];
                n++;
            end
        end
        @(posedge clk);
        pix_valid_i <= 1'b0;
        start_i     <= 1'b0;
        streaming = 1'b0;
    endtask

    task automatic wait_done();
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (frame_done_o !== 1'b1 && t < DONE_LIMIT);
        if (frame_done_o !== 1'b1) begin
            $display("Timeout: frame_done_o did not pulse within %0d cycles", DONE_LIMIT);
            errors++;
            aborted = 1'b1;
        end else begin
            @(negedge clk);
            check_flag("busy_o", busy_o, 1'b0);
            check_count("codes still expected", exp_code_q.size(), 0);
        end
    endtask

    task automatic run_frame(int kind, int gap_pct, bit poke_start);
        if (!aborted) begin
            fill_frame(kind);
            build_expected();
            @(posedge clk);
            start_i <= 1'b1;
            @(posedge clk);
            start_i <= 1'b0;
            drive_frame(gap_pct, poke_start);
            wait_done();
        end
    endtask

    task automatic report_test(string name, int err_before);
        tests++;
        if (errors != err_before) begin
            failed_tests++;
        end
        $display("Test %s: %0d errors", name, errors - err_before);
    endtask

    initial begin
        void'($urandom(32'h46a27ffb));
        rst_n       <= 1'b0;
        start_i     <= 1'b0;
        pix_valid_i <= 1'b0;
        pix_i       <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Pixels without a start must not wake the pipeline
        mark = errors;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_flag("code_valid_o", code_valid_o, 1'b0);
            check_flag("code_row_last_o", code_row_last_o, 1'b0);
            check_flag("frame_done_o", frame_done_o, 1'b0);
            check_flag("busy_o", busy_o, 1'b0);
            @(posedge clk);
            pix_valid_i <= 1'($urandom);
            pix_i       <= pixel_t'($urandom);
        end
        @(posedge clk);
        pix_valid_i <= 1'b0;
        report_test("reset_idle", mark);

        mark = errors;
        run_frame(0, 0, 1'b0);
        report_test("continuous_frame", mark);

        mark = errors;
        run_frame(0, 35, 1'b0);
        report_test("gapped_frame", mark);

        mark = errors;
        for (int k = 1; k <= 4; k++) begin
            run_frame(k, 10, 1'b0);
        end
        report_test("diagonal_patterns", mark);

        mark = errors;
        run_frame(0, 15, 1'b1);
        report_test("marks_and_late_start", mark);

        mark = errors;
        for (int f = 0; f < 3; f++) begin
            run_frame(0, 10 * f, 1'b0);
        end
        report_test("back_to_back", mark);

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* design/lbp_circle_interp.sv */
`timescale 1ns/10ps

`include "lbp_consts.svh"

module lbp_circle_interp (
    input  logic                         clk,
    input  logic                         rst_n,
    input  lbp_pixel_pkg::neighbourhood_t nbhd_i,
    output lbp_pixel_pkg::circle_t        circle_o
);
    import lbp_pixel_pkg::*;

    localparam int LAT = `LBP_INTERP_LAT;
    localparam int ONE = 1 << `LBP_FRAC_BITS;

    // Bilinear weights for the diagonal point, in 0.16
    localparam logic [16:0] W_CORNER =
        17'((`LBP_DIAG_FRAC * `LBP_DIAG_FRAC) >> `LBP_FRAC_BITS);
    localparam logic [16:0] W_EDGE  = 17'(`LBP_DIAG_FRAC) - W_CORNER;
    localparam logic [16:0] W_INNER = 17'(ONE - 2 * `LBP_DIAG_FRAC) + W_CORNER;

    pixel_t [3:0] card_d [LAT];
    pixel_t       centre_d [LAT];
    logic [LAT-1:0] valid_d;
    logic [LAT-1:0] row_last_d;

    logic [24:0] prod_q [4][4];
    logic [25:0] pair_q [4][2];
    sample_t     diag_q [4];

    always_ff @(posedge clk) begin
        card_d[0]   <= nbhd_i.card;
        centre_d[0] <= nbhd_i.centre;
        for (int i = 1; i < LAT; i++) begin
            card_d[i]   <= card_d[i-1];
            centre_d[i] <= centre_d[i-1];
        end

        for (int j = 0; j < 4; j++) begin
            // Stage 1 partial products
            prod_q[j][0] <= nbhd_i.diag[j].a * W_INNER;
            prod_q[j][1] <= nbhd_i.diag[j].b * W_EDGE;
            prod_q[j][2] <= nbhd_i.diag[j].c * W_EDGE;
            prod_q[j][3] <= nbhd_i.diag[j].d * W_CORNER;
            // Stage 2 pair sums
            pair_q[j][0] <= prod_q[j][0] + prod_q[j][1];
            pair_q[j][1] <= prod_q[j][2] + prod_q[j][3];
            // Stage 3
            diag_q[j] <= sample_t'(pair_q[j][0] + pair_q[j][1]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_d    <= '0;
            row_last_d <= '0;
        end else begin
            valid_d    <= {valid_d[LAT-2:0], nbhd_i.valid};
            row_last_d <= {row_last_d[LAT-2:0], nbhd_i.row_last};
        end
    end

    always_comb begin
        for (int j = 0; j < 4; j++) begin
            circle_o.samp[2*j]   = sample_t'(card_d[LAT-1][j]) << `LBP_FRAC_BITS;
            circle_o.samp[2*j+1] = diag_q[j];
        end
        circle_o.centre   = sample_t'(centre_d[LAT-1]) << `LBP_FRAC_BITS;
        circle_o.valid    = valid_d[LAT-1];
        circle_o.row_last = row_last_d[LAT-1];
    end

endmodule

/* design/lbp_code_encoder.sv */
`timescale 1ns/10ps

`include "lbp_consts.svh"

module lbp_code_encoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  lbp_pixel_pkg::circle_t   circle_i,
    output logic                    code_valid_o,
    output lbp_pixel_pkg::lbp_code_t code_o,
    output logic                    code_row_last_o,
    output logic                    last_code_o
);
    import lbp_pixel_pkg::*;

    localparam int N_CODES =
        (`LBP_IMG_W - 2 * `LBP_RADIUS) * (`LBP_IMG_H - 2 * `LBP_RADIUS);
    localparam int CW = $clog2(N_CODES);
    localparam logic [CW-1:0] LAST_IDX = CW'(N_CODES - 1);

    lbp_code_t     code_d;
    logic [CW-1:0] cnt_q;

    // Sample at or above the centre sets the bit
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            code_d[k] = (circle_i.samp[k] >= circle_i.centre);
        end
    end

    always_ff @(posedge clk) begin
        if (circle_i.valid) begin
            code_o <= code_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            code_valid_o    <= 1'b0;
            code_row_last_o <= 1'b0;
            last_code_o     <= 1'b0;
            cnt_q           <= '0;
        end else begin
            code_valid_o    <= circle_i.valid;
            code_row_last_o <= circle_i.valid && circle_i.row_last;
            last_code_o     <= circle_i.valid && (cnt_q == LAST_IDX);
            if (circle_i.valid) begin
                cnt_q <= (cnt_q == LAST_IDX) ? '0 : cnt_q + 1'b1;
            end
        end
    end

endmodule

/* design/lbp_consts.svh */
`ifndef LBP_CONSTS_SVH
`define LBP_CONSTS_SVH

// Frame geometry
`define LBP_IMG_W 16
`define LBP_IMG_H 12

// Sampling circle
`define LBP_RADIUS 2

// Radius over root two as whole pixels and a 16-bit fraction
`define LBP_DIAG_INT 1
`define LBP_DIAG_FRAC 27146

// Fixed point of the circle samples
`define LBP_FRAC_BITS 16

// Cycles through the interpolator
`define LBP_INTERP_LAT 3

`endif

/* design/lbp_ctrl_pkg.sv */
package lbp_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        STREAM,
        FLUSH,
        DONE
    } frame_state_t;

    // Position of the pixel being accepted
    typedef struct packed {
        logic [3:0] col;
        logic [3:0] row;
        logic       interior;
        logic       row_last;
    } raster_pos_t;

endpackage

/* design/lbp_frame_fsm.sv */
`timescale 1ns/10ps

module lbp_frame_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start_i,
    input  logic pix_valid_i,
    input  logic frame_last_i,
    input  logic last_code_i,
    output logic accept_o,
    output logic busy_o,
    output logic frame_done_o
);
    import lbp_ctrl_pkg::*;

    frame_state_t state_q;
    frame_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = STREAM;
                end
            end
            STREAM: begin
                // Final pixel taken while codes are still in the pipeline
                if (frame_last_i) begin
                    state_d = FLUSH;
                end
            end
            FLUSH: begin
                if (last_code_i) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign accept_o     = pix_valid_i && (state_q == STREAM);
    assign busy_o       = (state_q != IDLE);
    assign frame_done_o = (state_q == DONE);

endmodule

/* design/lbp_pixel_pkg.sv */
package lbp_pixel_pkg;

    typedef logic [7:0] pixel_t;

    // 8.16 fixed point
    typedef logic [23:0] sample_t;

    typedef logic [7:0] lbp_code_t;

    // Four grid pixels around one diagonal point
    typedef struct packed {
        pixel_t a;
        pixel_t b;
        pixel_t c;
        pixel_t d;
    } quad_t;

    // card[j] sits at angle 90*j, diag[j] at 45 + 90*j
    typedef struct packed {
        pixel_t       centre;
        pixel_t [3:0] card;
        quad_t  [3:0] diag;
        logic         valid;
        logic         row_last;
    } neighbourhood_t;

    // samp[k] belongs to code bit k
    typedef struct packed {
        sample_t [7:0] samp;
        sample_t       centre;
        logic          valid;
        logic          row_last;
    } circle_t;

endpackage

/* design/lbp_raster_counter.sv */
`timescale 1ns/10ps

`include "lbp_consts.svh"

module lbp_raster_counter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      accept_i,
    output lbp_ctrl_pkg::raster_pos_t pos_o,
    output logic                      frame_last_o
);
    localparam int EDGE = 2 * `LBP_RADIUS;

    localparam logic [3:0] LAST_COL = 4'(`LBP_IMG_W - 1);
    localparam logic [3:0] LAST_ROW = 4'(`LBP_IMG_H - 1);

    // Position of the next pixel to arrive
    logic [3:0] col_q;
    logic [3:0] row_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (accept_i) begin
            if (col_q == LAST_COL) begin
                col_q <= '0;
                row_q <= (row_q == LAST_ROW) ? 4'd0 : row_q + 4'd1;
            end else begin
                col_q <= col_q + 4'd1;
            end
        end
    end

    always_comb begin
        pos_o.col      = col_q;
        pos_o.row      = row_q;
        pos_o.interior = (col_q >= 4'(EDGE)) && (row_q >= 4'(EDGE));
        pos_o.row_last = (col_q == LAST_COL);
    end

    assign frame_last_o = accept_i && (col_q == LAST_COL) && (row_q == LAST_ROW);

endmodule

/* design/lbp_top.sv */
`timescale 1ns/10ps

module lbp_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  logic                    pix_valid_i,
    input  lbp_pixel_pkg::pixel_t    pix_i,
    output logic                    code_valid_o,
    output lbp_pixel_pkg::lbp_code_t code_o,
    output logic                    code_row_last_o,
    output logic                    frame_done_o,
    output logic                    busy_o
);
    import lbp_pixel_pkg::*;
    import lbp_ctrl_pkg::*;

    logic           accept;
    logic           frame_last;
    logic           last_code;
    raster_pos_t    pos;
    neighbourhood_t nbhd;
    circle_t        circle;

    lbp_frame_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .pix_valid_i  (pix_valid_i),
        .frame_last_i (frame_last),
        .last_code_i  (last_code),
        .accept_o     (accept),
        .busy_o       (busy_o),
        .frame_done_o (frame_done_o)
    );

    lbp_raster_counter u_counter (
        .clk          (clk),
        .rst_n        (rst_n),
        .accept_i     (accept),
        .pos_o        (pos),
        .frame_last_o (frame_last)
    );

    lbp_window u_window (
        .clk      (clk),
        .rst_n    (rst_n),
        .accept_i (accept),
        .pix_i    (pix_i),
        .pos_i    (pos),
        .nbhd_o   (nbhd)
    );

    lbp_circle_interp u_interp (
        .clk      (clk),
        .rst_n    (rst_n),
        .nbhd_i   (nbhd),
        .circle_o (circle)
    );

    lbp_code_encoder u_encoder (
        .clk             (clk),
        .rst_n           (rst_n),
        .circle_i        (circle),
        .code_valid_o    (code_valid_o),
        .code_o          (code_o),
        .code_row_last_o (code_row_last_o),
        .last_code_o     (last_code)
    );

endmodule

/* design/lbp_window.sv */
`timescale 1ns/10ps

`include "lbp_consts.svh"

module lbp_window (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         accept_i,
    input  lbp_pixel_pkg::pixel_t         pix_i,
    input  lbp_ctrl_pkg::raster_pos_t     pos_i,
    output lbp_pixel_pkg::neighbourhood_t nbhd_o
);
    import lbp_pixel_pkg::*;

    localparam int R     = `LBP_RADIUS;
    localparam int WIN   = 2 * R + 1;
    localparam int LINES = 2 * R;

    // Window rows and columns of the diagonal quads
    localparam int IN_LO  = R - `LBP_DIAG_INT;
    localparam int OUT_LO = R - `LBP_DIAG_INT - 1;
    localparam int IN_HI  = R + `LBP_DIAG_INT;
    localparam int OUT_HI = R + `LBP_DIAG_INT + 1;

    // lb[0] holds the row just above the incoming one
    pixel_t lb [LINES][`LBP_IMG_W];

    // Older window columns
    // Index WIN-2 is the newest stored
    pixel_t cols_q [WIN][WIN-1];

    pixel_t col_in [WIN];
    pixel_t w [WIN][WIN];

    pixel_t       centre_q;
    pixel_t [3:0] card_q;
    quad_t  [3:0] diag_q;
    logic         valid_q;
    logic         row_last_q;

    // Window as it stands once the current pixel is in
    always_comb begin
        col_in[WIN-1] = pix_i;
        for (int r = 0; r < WIN - 1; r++) begin
            col_in[r] = lb[WIN-2-r][pos_i.col];
        end
        for (int r = 0; r < WIN; r++) begin
            for (int c = 0; c < WIN - 1; c++) begin
                w[r][c] = cols_q[r][c];
            end
            w[r][WIN-1] = col_in[r];
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            lb[0][pos_i.col] <= pix_i;
            for (int i = 1; i < LINES; i++) begin
                lb[i][pos_i.col] <= lb[i-1][pos_i.col];
            end
            for (int r = 0; r < WIN; r++) begin
                for (int c = 0; c < WIN - 2; c++) begin
                    cols_q[r][c] <= cols_q[r][c+1];
                end
                cols_q[r][WIN-2] <= col_in[r];
            end

            centre_q <= w[R][R];
            card_q[0] <= w[R][2*R];
            card_q[1] <= w[0][R];
            card_q[2] <= w[R][0];
            card_q[3] <= w[2*R][R];

            // a inner, b column outer, c row outer, d corner
            diag_q[0] <= '{a: w[IN_LO][IN_HI], b: w[IN_LO][OUT_HI],
                           c: w[OUT_LO][IN_HI], d: w[OUT_LO][OUT_HI]};
            diag_q[1] <= '{a: w[IN_LO][IN_LO], b: w[IN_LO][OUT_LO],
                           c: w[OUT_LO][IN_LO], d: w[OUT_LO][OUT_LO]};
            diag_q[2] <= '{a: w[IN_HI][IN_LO], b: w[IN_HI][OUT_LO],
                           c: w[OUT_HI][IN_LO], d: w[OUT_HI][OUT_LO]};
            diag_q[3] <= '{a: w[IN_HI][IN_HI], b: w[IN_HI][OUT_HI],
                           c: w[OUT_HI][IN_HI], d: w[OUT_HI][OUT_HI]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q    <= 1'b0;
            row_last_q <= 1'b0;
        end else begin
            valid_q    <= accept_i && pos_i.interior;
            row_last_q <= accept_i && pos_i.interior && pos_i.row_last;
        end
    end

    assign nbhd_o = '{centre: centre_q, card: card_q, diag: diag_q,
                      valid: valid_q, row_last: row_last_q};

endmodule

/* project.f */
+incdir+design
+incdir+bench
design/lbp_pixel_pkg.sv
design/lbp_ctrl_pkg.sv
design/lbp_frame_fsm.sv
design/lbp_raster_counter.sv
design/lbp_window.sv
design/lbp_circle_interp.sv
design/lbp_code_encoder.sv
design/lbp_top.sv
bench/lbp_tb.sv
